// ==== compile.f ====
source/eth_tx_pkg.sv
source/eth_hdr_latch.sv
source/payload_shift.sv
source/frame_merge.sv
source/axis_out_reg.sv
source/eth_frame_tx.sv
bench/eth_frame_tx_sva.sv
bench/eth_frame_tx_tb.sv

// ==== bench/eth_frame_tx_tb.sv ====
/*
 * Testbench for the 64-bit Ethernet frame transmitter.
 * Queues headers and payload beats for drivers that run on the clock,
 * builds the expected byte sequence of every frame and checks each
 * accepted output beat against it. A watchdog ends a stuck run.
 */

`timescale 1ns/1ps
`default_nettype none

module eth_frame_tx_tb import eth_tx_pkg::*; ();

    logic         clk;
    logic         rst;
    logic         hdr_valid = 1'b0;
    logic         hdr_ready;
    eth_hdr_t     hdr = '0;
    logic         s_valid = 1'b0;
    logic         s_ready;
    stream_word_t s_word = '0;
    logic         m_valid;
    logic         m_ready = 1'b0;
    stream_word_t m_word;
    logic         busy;

    // stimulus waiting for the drivers
    eth_hdr_t     hdr_q[$];
    stream_word_t beat_q[$];
    // expected frames, one length and user flag each
    logic [7:0]   exp_bytes[$];
    int           exp_len[$];
    logic         exp_user[$];
    logic [7:0]   pay_buf[0:127];

    int stall_pct = 0;
    int gap_pct = 0;
    int err_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycle_count = 0;
    int cycle_limit = 2000;

    // comparator state for the frame in progress
    logic in_frame = 1'b0;
    logic cur_user;
    int   cur_len;
    int   bytes_left;
    int   words_seen;

    eth_frame_tx dut (
        .clk       (clk),
        .rst       (rst),
        .hdr_valid (hdr_valid),
        .hdr_ready (hdr_ready),
        .hdr       (hdr),
        .s_valid   (s_valid),
        .s_ready   (s_ready),
        .s_word    (s_word),
        .m_valid   (m_valid),
        .m_ready   (m_ready),
        .m_word    (m_word),
        .busy      (busy)
    );

    bind eth_frame_tx eth_frame_tx_sva u_sva (
        .clk       (clk),
        .rst       (rst),
        .hdr_ready (hdr_ready),
        .s_ready   (s_ready),
        .m_valid   (m_valid),
        .m_ready   (m_ready),
        .m_word    (m_word)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // header source, valid held until accepted
    always @(posedge clk) begin
        if (rst) begin
            hdr_valid <= 1'b0;
        end else if (!hdr_valid || hdr_ready) begin
            if (hdr_q.size() > 0) begin
                hdr <= hdr_q.pop_front();
                hdr_valid <= 1'b1;
            end else begin
                hdr_valid <= 1'b0;
            end
        end
    end

    // payload source with random gaps
    always @(posedge clk) begin
        if (rst) begin
            s_valid <= 1'b0;
        end else if (!s_valid || s_ready) begin
            if (beat_q.size() > 0 && int'($urandom % 100) >= gap_pct) begin
                s_word <= beat_q.pop_front();
                s_valid <= 1'b1;
            end else begin
                s_valid <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        m_ready <= int'($urandom % 100) >= stall_pct;
    end

    always @(posedge clk) begin
        if (!rst && m_valid && m_ready) begin
            check_word(m_word);
        end
    end

    initial begin
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, %0d frames never completed at the output",
                 cycle_count, exp_len.size() + int'(in_frame));
        $display("Something failed");
        $finish;
    end

    task automatic report_mismatch(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        err_count++;
    endtask

    // wire order: dest MAC, source MAC, ethertype, then payload
    function automatic void build_expected(input eth_hdr_t h, input int len,
                                           input logic user_flag);
        for (int i = 0; i < 6; i++) begin
            exp_bytes.push_back(h.dest_mac[(5 - i) * 8 +: 8]);
        end
        for (int i = 0; i < 6; i++) begin
            exp_bytes.push_back(h.src_mac[(5 - i) * 8 +: 8]);
        end
        exp_bytes.push_back(h.eth_type[15:8]);
        exp_bytes.push_back(h.eth_type[7:0]);
        for (int i = 0; i < len; i++) begin
            exp_bytes.push_back(pay_buf[i]);
        end
        exp_len.push_back(HDR_BYTES + len);
        exp_user.push_back(user_flag);
    endfunction

    task automatic queue_frame(input int len, input logic user_flag);
        eth_hdr_t     h;
        stream_word_t w;
        int           nbeats;
        h.dest_mac = {16'($urandom), $urandom};
        h.src_mac = {16'($urandom), $urandom};
        h.eth_type = 16'($urandom);
        for (int i = 0; i < len; i++) begin
            pay_buf[i] = 8'($urandom);
        end
        build_expected(h, len, user_flag);
        nbeats = (len + 7) / 8;
        for (int b = 0; b < nbeats; b++) begin
            w = '0;
            for (int l = 0; l < 8; l++) begin
                if (b * 8 + l < len) begin
                    w.data[l * 8 +: 8] = pay_buf[b * 8 + l];
                    w.keep[l] = 1'b1;
                end
            end
            w.last = (b == nbeats - 1);
            w.user = w.last && user_flag;
            beat_q.push_back(w);
        end
        hdr_q.push_back(h);
        cycle_limit += 4 * (HDR_BYTES + len);
    endtask

    task automatic check_word(input stream_word_t w);
        int         n_lanes;
        logic [7:0] exp_keep;
        logic [7:0] exp_byte;
        logic       exp_last;
        if (!in_frame) begin
            assert (exp_len.size() > 0) else begin
                $display("output word at %0t ns arrived with no frame queued", $time);
                err_count++;
            end
            if (exp_len.size() == 0) begin
                return;
            end
            cur_len = exp_len.pop_front();
            cur_user = exp_user.pop_front();
            bytes_left = cur_len;
            words_seen = 0;
            in_frame = 1'b1;
        end
        n_lanes = (bytes_left < 8) ? bytes_left : 8;
        exp_keep = 8'((16'd1 << n_lanes) - 16'd1);
        exp_last = (bytes_left <= 8);
        words_seen++;
        assert (w.keep == exp_keep) else
            report_mismatch($sformatf("keep %02h on word %0d, expected %02h",
                                      w.keep, words_seen, exp_keep));
        for (int l = 0; l < n_lanes; l++) begin
            exp_byte = exp_bytes.pop_front();
            if (w.keep[l]) begin
                assert (w.data[l * 8 +: 8] == exp_byte) else
                    report_mismatch($sformatf("frame byte %0d is %02h, expected %02h",
                                              cur_len - bytes_left + l,
                                              w.data[l * 8 +: 8], exp_byte));
            end
        end
        assert (w.last == exp_last) else
            report_mismatch($sformatf("last %0b on word %0d", w.last, words_seen));
        assert (w.user == (exp_last && cur_user)) else
            report_mismatch($sformatf("user %0b on word %0d", w.user, words_seen));
        bytes_left -= n_lanes;
        // the frame ends where the DUT marks last
        if (w.last) begin
            // ceil of frame bytes over the word width
            assert (words_seen == (cur_len + 7) / 8) else
                report_mismatch($sformatf("frame of %0d bytes took %0d words",
                                          cur_len, words_seen));
            // drop the rest of a frame that ended early
            while (bytes_left > 0) begin
                void'(exp_bytes.pop_front());
                bytes_left--;
            end
            in_frame = 1'b0;
        end
    endtask

    task automatic run_test(input string name, input int nframes, input int len_lo,
                            input int len_hi, input int stall, input int gap,
                            input logic with_user, input logic sweep);
        int errs_before;
        int len;
        errs_before = err_count;
        stall_pct = stall;
        gap_pct = gap;
        for (int i = 0; i < nframes; i++) begin
            if (sweep) begin
                len = len_lo + i;
            end else begin
                len = len_lo + int'($urandom % (len_hi - len_lo + 1));
            end
            queue_frame(len, with_user && (i % 2 == 1));
        end
        while (exp_len.size() > 0 || in_frame) begin
            @(posedge clk);
        end
        @(posedge clk);
        assert (!busy) else report_mismatch("busy still high after the last word");
        tests_run++;
        if (err_count != errs_before) begin
            tests_failed++;
        end
        $display("test %-12s %s, %0d frames", name,
                 (err_count == errs_before) ? "passed" : "FAILED", nframes);
    endtask

    initial begin
        void'($urandom(32'hd2de2740));
        rst = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        // values left by the last reset edge
        @(posedge clk);
        assert (!hdr_ready && !s_ready && !m_valid && !busy) else
            report_mismatch("outputs not idle after reset");
        @(posedge clk);
        assert (hdr_ready && !busy) else
            report_mismatch("hdr_ready did not rise after reset release");
        tests_run++;
        tests_failed += (err_count != 0) ? 1 : 0;
        $display("test %-12s %s", "reset", (err_count == 0) ? "passed" : "FAILED");

        run_test("short", 6, 1, 2, 0, 0, 1'b0, 1'b0);
        run_test("sweep", 78, 3, 80, 0, 0, 1'b0, 1'b1);
        run_test("stalls", 30, 1, 80, 40, 30, 1'b0, 1'b0);
        run_test("user_flag", 12, 1, 24, 20, 10, 1'b1, 1'b0);
        run_test("back_to_back", 20, 1, 80, 0, 0, 1'b0, 1'b0);

        err_count += dut.u_sva.fail_count;
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/eth_frame_tx_sva.sv ====
/*
 * Protocol assertions on the ports of the frame transmitter.
 * Attached to the top level with bind from the testbench.
 */

`timescale 1ns/1ps
`default_nettype none

module eth_frame_tx_sva import eth_tx_pkg::*; (
    input logic         clk,
    input logic         rst,
    input logic         hdr_ready,
    input logic         s_ready,
    input logic         m_valid,
    input logic         m_ready,
    input stream_word_t m_word
);

    int fail_count = 0;

    // a stalled output beat holds still until taken
    out_stable: assert property (@(posedge clk) disable iff (rst)
        m_valid && !m_ready |=> m_valid && $stable(m_word))
    else begin
        $error("m_valid or m_word changed while the sink was stalling");
        fail_count++;
    end

    reset_idle: assert property (@(posedge clk) rst |=> !hdr_ready && !s_ready && !m_valid)
    else begin
        $error("handshake outputs active in the cycle after reset");
        fail_count++;
    end

    keep_nonzero: assert property (@(posedge clk) disable iff (rst)
        m_valid |-> m_word.keep != 8'h00)
    else begin
        $error("output beat with an empty keep mask");
        fail_count++;
    end

endmodule

`default_nettype wire

// ==== source/eth_frame_tx.sv ====
/*
 * 64-bit Ethernet frame transmitter, top level.
 * Takes a parallel header and a byte-keyed payload stream and sends the
 * complete frame, header first, as one 64-bit stream. Only wiring here.
 */

`timescale 1ns/1ps
`default_nettype none

module eth_frame_tx import eth_tx_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         hdr_valid,
    output logic         hdr_ready,
    input  eth_hdr_t     hdr,
    input  logic         s_valid,
    output logic         s_ready,
    input  stream_word_t s_word,
    output logic         m_valid,
    input  logic         m_ready,
    output stream_word_t m_word,
    output logic         busy
);

    stream_word_t                hdr_word;
    logic [HDR_TAIL_LANES*8-1:0] hdr_tail;
    logic                        hdr_full;
    logic                        hdr_take;
    stream_word_t                sh_word;
    logic                        sh_valid;
    logic                        sh_ready;
    logic                        first;
    stream_word_t                int_word;
    logic                        int_valid;
    logic                        int_ready;

    eth_hdr_latch u_hdr_latch (
        .clk       (clk),
        .rst       (rst),
        .hdr_valid (hdr_valid),
        .hdr_ready (hdr_ready),
        .hdr       (hdr),
        .hdr_take  (hdr_take),
        .hdr_word  (hdr_word),
        .hdr_tail  (hdr_tail),
        .hdr_full  (hdr_full)
    );

    payload_shift u_payload_shift (
        .clk      (clk),
        .rst      (rst),
        .s_valid  (s_valid),
        .s_ready  (s_ready),
        .s_word   (s_word),
        .sh_word  (sh_word),
        .sh_valid (sh_valid),
        .sh_ready (sh_ready),
        .first    (first)
    );

    frame_merge u_frame_merge (
        .clk       (clk),
        .rst       (rst),
        .hdr_word  (hdr_word),
        .hdr_tail  (hdr_tail),
        .hdr_full  (hdr_full),
        .hdr_take  (hdr_take),
        .sh_word   (sh_word),
        .sh_valid  (sh_valid),
        .first     (first),
        .sh_ready  (sh_ready),
        .int_word  (int_word),
        .int_valid (int_valid),
        .int_ready (int_ready),
        .busy      (busy)
    );

    axis_out_reg u_axis_out_reg (
        .clk       (clk),
        .rst       (rst),
        .int_word  (int_word),
        .int_valid (int_valid),
        .int_ready (int_ready),
        .m_word    (m_word),
        .m_valid   (m_valid),
        .m_ready   (m_ready)
    );

endmodule

`default_nettype wire

// ==== source/axis_out_reg.sv ====
/*
 * Two-entry output register between the frame merger and the sink.
 * A main and a temporary register hold up to two words. int_ready is
 * registered from the fill state, so m_ready never reaches the merger
 * combinationally.
 */

`timescale 1ns/1ps
`default_nettype none

module axis_out_reg import eth_tx_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  stream_word_t int_word,
    input  logic         int_valid,
    output logic         int_ready,
    output stream_word_t m_word,
    output logic         m_valid,
    input  logic         m_ready
);

    stream_word_t tmp_word;
    logic         tmp_valid;
    logic         m_valid_next;
    logic         tmp_valid_next;
    logic         int_ready_early;
    logic         store_int_to_out;
    logic         store_int_to_tmp;
    logic         store_tmp_to_out;

    // ready next cycle unless the temp register could fill up
    assign int_ready_early = m_ready || (!tmp_valid && (!m_valid || !int_valid));

    always_comb begin
        m_valid_next = m_valid;
        tmp_valid_next = tmp_valid;
        store_int_to_out = 1'b0;
        store_int_to_tmp = 1'b0;
        store_tmp_to_out = 1'b0;

        if (int_ready) begin
            if (m_ready || !m_valid) begin
                m_valid_next = int_valid;
                store_int_to_out = 1'b1;
            end else begin
                tmp_valid_next = int_valid;
                store_int_to_tmp = 1'b1;
            end
        end else if (m_ready) begin
            // drain the temp word into the output slot
            m_valid_next = tmp_valid;
            tmp_valid_next = 1'b0;
            store_tmp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid <= 1'b0;
            tmp_valid <= 1'b0;
            int_ready <= 1'b0;
        end else begin
            m_valid <= m_valid_next;
            tmp_valid <= tmp_valid_next;
            int_ready <= int_ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (store_int_to_out) begin
            m_word <= int_word;
        end else if (store_tmp_to_out) begin
            m_word <= tmp_word;
        end
        if (store_int_to_tmp) begin
            tmp_word <= int_word;
        end
    end

endmodule

`default_nettype wire

// ==== source/frame_merge.sv ====
/*
 * Frame sequencer for the transmitter.
 * Waits for a latched header, sends header word 0, then builds word 1
 * from the header tail and the first shifted payload word. Remaining
 * shifted words pass straight through until last. The result goes to
 * the output register over an internal valid/ready stream.
 */

`timescale 1ns/1ps
`default_nettype none

module frame_merge import eth_tx_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  stream_word_t                hdr_word,
    input  logic [HDR_TAIL_LANES*8-1:0] hdr_tail,
    input  logic                        hdr_full,
    output logic                        hdr_take,
    input  stream_word_t                sh_word,
    input  logic                        sh_valid,
    input  logic                        first,
    output logic                        sh_ready,
    output stream_word_t                int_word,
    output logic                        int_valid,
    input  logic                        int_ready,
    output logic                        busy
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HDR,
        ST_HDR_PL,
        ST_PAYLOAD
    } state_t;

    state_t state;
    state_t state_next;

    assign busy = (state != ST_IDLE) || hdr_full;

    always_comb begin
        state_next = state;
        int_word = '0;
        int_valid = 1'b0;
        sh_ready = 1'b0;
        hdr_take = 1'b0;

        case (state)
            ST_IDLE: begin
                if (hdr_full) begin
                    state_next = ST_HDR;
                end
            end
            ST_HDR: begin
                int_word = hdr_word;
                int_valid = 1'b1;
                if (int_ready) begin
                    state_next = ST_HDR_PL;
                end
            end
            ST_HDR_PL: begin
                // header tail in the low lanes, first payload lanes on top
                sh_ready = int_ready && first;
                int_valid = sh_valid && first;
                int_word.data = {sh_word.data[63:(8-SHIFT_LANES)*8], hdr_tail};
                int_word.keep = {sh_word.keep[7:8-SHIFT_LANES], {HDR_TAIL_LANES{1'b1}}};
                int_word.last = sh_word.last;
                int_word.user = sh_word.user;
                if (int_valid && int_ready) begin
                    hdr_take = 1'b1;
                    if (sh_word.last) begin
                        state_next = ST_IDLE;
                    end else begin
                        state_next = ST_PAYLOAD;
                    end
                end
            end
            ST_PAYLOAD: begin
                sh_ready = int_ready;
                int_valid = sh_valid;
                int_word = sh_word;
                if (sh_valid && int_ready && sh_word.last) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

// ==== source/payload_shift.sv ====
/*
 * Payload realignment for the frame transmitter.
 * The header fills six lanes of word 1 and leaves two for payload, so each
 * output word takes the upper lanes of the previous beat plus the lowest
 * two lanes of the current one. When the final beat does not fit, a flush
 * word carrying last and user follows. s_ready is withheld while it is pending.
 */

`timescale 1ns/1ps
`default_nettype none

module payload_shift import eth_tx_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         s_valid,
    output logic         s_ready,
    input  stream_word_t s_word,
    output stream_word_t sh_word,
    output logic         sh_valid,
    input  logic         sh_ready,
    output logic         first
);

    localparam int SAVE_LANES = 8 - SHIFT_LANES;

    logic [SAVE_LANES*8-1:0] save_data;
    logic [SAVE_LANES-1:0]   save_keep;
    logic                    save_user;
    logic                    pending;
    logic                    overflow;
    logic                    s_fire;
    logic                    sh_fire;

    // final beat spills past the lanes left in the current output word
    assign overflow = |s_word.keep[7:SHIFT_LANES];

    assign s_ready = sh_ready && !pending;
    assign s_fire = s_valid && s_ready;
    assign sh_fire = sh_valid && sh_ready;

    always_comb begin
        sh_word = '0;
        if (pending) begin
            // flush word with only the saved lanes
            sh_word.data[SAVE_LANES*8-1:0] = save_data;
            sh_word.keep[SAVE_LANES-1:0] = save_keep;
            sh_word.last = 1'b1;
            sh_word.user = save_user;
            sh_valid = 1'b1;
        end else begin
            sh_word.data = {s_word.data[SHIFT_LANES*8-1:0], save_data};
            sh_word.keep = {s_word.keep[SHIFT_LANES-1:0], save_keep};
            sh_word.last = s_word.last && !overflow;
            sh_word.user = s_word.user && !overflow;
            sh_valid = s_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            save_keep <= '0;
            first <= 1'b1;
        end else begin
            if (sh_fire) begin
                first <= sh_word.last;
            end
            if (pending && sh_fire) begin
                pending <= 1'b0;
                save_keep <= '0;
            end else if (s_fire) begin
                pending <= s_word.last && overflow;
                // start the next frame with empty low lanes
                if (s_word.last && !overflow) begin
                    save_keep <= '0;
                end else begin
                    save_keep <= s_word.keep[7:SHIFT_LANES];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s_fire) begin
            save_data <= s_word.data[63:SHIFT_LANES*8];
            save_user <= s_word.user;
        end
    end

endmodule

`default_nettype wire

// ==== source/eth_hdr_latch.sv ====
/*
 * Single-entry holding register for the Ethernet header.
 * Accepts a header on a valid/ready handshake and presents it in wire
 * byte order: the first eight bytes as a full stream word and the
 * remaining bytes as a tail for the second output word. The latch is
 * released when the merger pulses hdr_take.
 */

`timescale 1ns/1ps
`default_nettype none

module eth_hdr_latch import eth_tx_pkg::*; (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         hdr_valid,
    output logic                         hdr_ready,
    input  eth_hdr_t                     hdr,
    input  logic                         hdr_take,
    output stream_word_t                 hdr_word,
    output logic [(HDR_BYTES-8)*8-1:0]   hdr_tail,
    output logic                         hdr_full
);

    eth_hdr_t                 hdr_q;
    logic [HDR_BYTES*8-1:0]   wire_bytes;
    logic                     hdr_fire;
    logic                     full_next;

    assign hdr_fire = hdr_valid && hdr_ready;
    assign full_next = (hdr_full && !hdr_take) || hdr_fire;

    // ready is registered, so it comes up one cycle after the latch empties
    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_full <= 1'b0;
            hdr_ready <= 1'b0;
        end else begin
            hdr_full <= full_next;
            hdr_ready <= !full_next;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_fire) begin
            hdr_q <= hdr;
        end
    end

    // byte k on the wire is byte k counted from the top of the struct
    always_comb begin
        for (int k = 0; k < HDR_BYTES; k++) begin
            wire_bytes[k*8 +: 8] = hdr_q[(HDR_BYTES-1-k)*8 +: 8];
        end
    end

    always_comb begin
        hdr_word = '0;
        hdr_word.data = wire_bytes[63:0];
        hdr_word.keep = 8'hff;
        hdr_tail = wire_bytes[HDR_BYTES*8-1:64];
    end

endmodule

`default_nettype wire

// ==== source/eth_tx_pkg.sv ====
/*
 * Shared types and constants for the 64-bit Ethernet frame transmitter.
 * Modules pull these in with a wildcard import in their headers.
 * Stream beats carry byte lane 0 in the lowest data bits. Header fields
 * are sent most significant byte first.
 */

`default_nettype none

package eth_tx_pkg;

    // one beat of a 64-bit byte stream
    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  keep;
        logic        last;
        // error mark, meaningful on the last beat only
        logic        user;
    } stream_word_t;

    // parallel Ethernet header as presented by the source
    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    // header length on the wire
    localparam int HDR_BYTES = 14;

    // header bytes that spill into output word 1
    localparam int HDR_TAIL_LANES = 6;

    // payload lanes taken from the current beat into each output word
    localparam int SHIFT_LANES = 2;

endpackage

`default_nettype wire
